//--- design/complex_mult.sv
`timescale 1ns/1ps
`include "fft_params.svh"

// (a + jb)(c + jd) = (ac - bd) + j(ad + bc) scaled by 2^-10
module complex_mult (
    input  fft_twiddle_pkg::cplx_word_u data_in,
    input  fft_twiddle_pkg::tw_part_t   tw_re,
    input  fft_twiddle_pkg::tw_part_t   tw_im,
    output fft_twiddle_pkg::cplx_word_u data_out
);

    logic signed [`FFT_ACC_W-1:0] prod_rr;  // tw_re * re
    logic signed [`FFT_ACC_W-1:0] prod_ii;  // tw_im * im
    logic signed [`FFT_ACC_W-1:0] prod_ir;  // tw_im * re
    logic signed [`FFT_ACC_W-1:0] prod_ri;  // tw_re * im
    logic signed [`FFT_ACC_W-1:0] acc_re;
    logic signed [`FFT_ACC_W-1:0] acc_im;
    logic signed [`FFT_ACC_W-1:0] scaled_re;
    logic signed [`FFT_ACC_W-1:0] scaled_im;

    always_comb begin
        // sign-extend before multiplying so the full product is kept
        prod_rr = `FFT_ACC_W'(tw_re) * `FFT_ACC_W'(data_in.parts.re);
        prod_ii = `FFT_ACC_W'(tw_im) * `FFT_ACC_W'(data_in.parts.im);
        prod_ir = `FFT_ACC_W'(tw_im) * `FFT_ACC_W'(data_in.parts.re);
        prod_ri = `FFT_ACC_W'(tw_re) * `FFT_ACC_W'(data_in.parts.im);

        acc_re = prod_rr - prod_ii;
        acc_im = prod_ir + prod_ri;

        // arithmetic shift rounds toward minus infinity
        scaled_re = acc_re >>> `FFT_TW_FRAC;
        scaled_im = acc_im >>> `FFT_TW_FRAC;

        // keep the low 16 bits so overflow wraps
        data_out.parts.re = scaled_re[`FFT_PART_W-1:0];
        data_out.parts.im = scaled_im[`FFT_PART_W-1:0];
    end

endmodule

//--- design/fft_twiddle_pkg.sv
`include "fft_params.svh"

package fft_twiddle_pkg;

    // one real or imaginary part of a sample
    typedef logic signed [`FFT_PART_W-1:0] part_t;

    // one part of a twiddle factor in Q1.10
    typedef logic signed [`FFT_TW_W-1:0] tw_part_t;

    // address into the coefficient table
    typedef logic [`FFT_TW_IDX_W-1:0] tw_idx_t;

    // bus word seen either as raw bits or as its two parts
    typedef union packed {
        logic [`FFT_SAMPLE_W-1:0] raw;
        struct packed {
            part_t re;  // upper half
            part_t im;  // lower half
        } parts;
    } cplx_word_u;

endpackage

//--- design/twiddle_addr_gen.sv
`timescale 1ns/1ps
`include "fft_params.svh"

// maps the schedule counter onto a twiddle table index
//   stage s (group g = s - 2) repeats with period 2^(g+1)
//   and steps through the table with stride 16 / 2^g
module twiddle_addr_gen (
    input  logic [`FFT_CNT_W-1:0]    cnt,
    output fft_twiddle_pkg::tw_idx_t tw_idx
);

    logic [`FFT_CNT_W-1:0]    offset;
    logic                     below;   // stage 1 where the twiddle is always 1
    logic [2:0]               grp;     // 0..4 for stages 2..6
    logic [2:0]               shamt;   // log2 of the stride
    fft_twiddle_pkg::tw_idx_t pos;
    fft_twiddle_pkg::tw_idx_t mask;

    always_comb begin
        below  = cnt < `FFT_CNT_W'(`FFT_START_CNT);
        offset = cnt - `FFT_CNT_W'(`FFT_START_CNT);

        grp = 3'(offset / `FFT_STAGE_LEN);
        pos = fft_twiddle_pkg::tw_idx_t'(offset % `FFT_STAGE_LEN);

        // an 8-bit count never reaches group 5 so shamt cannot underflow
        shamt = 3'(`FFT_TW_IDX_W - 1) - grp;

        // period 2^(g+1) keeps the low g+1 bits of the position
        mask = {`FFT_TW_IDX_W{1'b1}} >> shamt;

        if (below) begin
            tw_idx = '0;
        end else begin
            tw_idx = (pos & mask) << shamt;  // scale by the stride
        end
    end

endmodule

//--- design/twiddle_mult.sv
`timescale 1ns/1ps
`include "fft_params.svh"

// twiddle multiplier between FFT stages
// the twiddle for cnt is applied to the sample one clock later
module twiddle_mult (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`FFT_CNT_W-1:0]       cnt,
    input  fft_twiddle_pkg::cplx_word_u data_in,
    output fft_twiddle_pkg::cplx_word_u data_out
);

    fft_twiddle_pkg::tw_idx_t  tw_idx;
    fft_twiddle_pkg::tw_part_t tw_re;
    fft_twiddle_pkg::tw_part_t tw_im;

    twiddle_addr_gen u_addr_gen (
        .cnt    (cnt),
        .tw_idx (tw_idx)
    );

    twiddle_rom u_rom (
        .clk    (clk),
        .rst_n  (rst_n),
        .tw_idx (tw_idx),
        .tw_re  (tw_re),
        .tw_im  (tw_im)
    );

    // purely combinational from data_in to data_out
    complex_mult u_mult (
        .data_in  (data_in),
        .tw_re    (tw_re),
        .tw_im    (tw_im),
        .data_out (data_out)
    );

endmodule

//--- design/twiddle_rom.sv
`timescale 1ns/1ps
`include "fft_params.svh"

// W64^k = cos(2*pi*k/64) - j*sin(2*pi*k/64) for k = 0..31 in Q1.10
module twiddle_rom (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fft_twiddle_pkg::tw_idx_t  tw_idx,
    output fft_twiddle_pkg::tw_part_t tw_re,
    output fft_twiddle_pkg::tw_part_t tw_im
);

    logic [2*`FFT_TW_W-1:0] coef;  // {re, im}

    always_comb begin
        case (tw_idx)
            5'd0:  coef = {12'b010000000000, 12'b000000000000};
            5'd1:  coef = {12'b001111111011, 12'b111110011011};
            5'd2:  coef = {12'b001111101100, 12'b111100111000};
            5'd3:  coef = {12'b001111010011, 12'b111011010110};
            5'd4:  coef = {12'b001110110010, 12'b111001111000};
            5'd5:  coef = {12'b001110000111, 12'b111000011101};
            5'd6:  coef = {12'b001101010011, 12'b110111000111};
            5'd7:  coef = {12'b001100010111, 12'b110101110110};
            5'd8:  coef = {12'b001011010100, 12'b110100101011};  // e^(-j pi/4)
            5'd9:  coef = {12'b001010001001, 12'b110011101000};
            5'd10: coef = {12'b001000111000, 12'b110010101100};
            5'd11: coef = {12'b000111100010, 12'b110001111000};
            5'd12: coef = {12'b000110000111, 12'b110001001101};
            5'd13: coef = {12'b000100101001, 12'b110000101100};
            5'd14: coef = {12'b000011000111, 12'b110000010011};
            5'd15: coef = {12'b000001100100, 12'b110000000100};
            5'd16: coef = {12'b000000000000, 12'b110000000000};  // -j
            5'd17: coef = {12'b111110011011, 12'b110000000100};
            5'd18: coef = {12'b111100111000, 12'b110000010011};
            5'd19: coef = {12'b111011010110, 12'b110000101100};
            5'd20: coef = {12'b111001111000, 12'b110001001101};
            5'd21: coef = {12'b111000011101, 12'b110001111000};
            5'd22: coef = {12'b110111000111, 12'b110010101100};
            5'd23: coef = {12'b110101110110, 12'b110011101000};
            5'd24: coef = {12'b110100101011, 12'b110100101011};
            5'd25: coef = {12'b110011101000, 12'b110101110110};
            5'd26: coef = {12'b110010101100, 12'b110111000111};
            5'd27: coef = {12'b110001111000, 12'b111000011101};
            5'd28: coef = {12'b110001001101, 12'b111001111000};
            5'd29: coef = {12'b110000101100, 12'b111011010110};
            5'd30: coef = {12'b110000010011, 12'b111100111000};
            5'd31: coef = {12'b110000000100, 12'b111110011011};
        endcase
    end

    // coefficient register comes up as W(0) = 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tw_re <= fft_twiddle_pkg::tw_part_t'(1 << `FFT_TW_FRAC);
            tw_im <= '0;
        end else begin
            tw_re <= coef[2*`FFT_TW_W-1:`FFT_TW_W];
            tw_im <= coef[`FFT_TW_W-1:0];
        end
    end

endmodule

//--- include/fft_params.svh
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

// sample is {re, im} with two's complement parts
`define FFT_SAMPLE_W   32
`define FFT_PART_W     16

// twiddle is Q1.10 in 12 bits so 1.0 is 1024
`define FFT_TW_W       12
`define FFT_TW_FRAC    10

// half a turn of W64 in 32 entries
`define FFT_TW_NUM     32
`define FFT_TW_IDX_W   $clog2(`FFT_TW_NUM)

// multiply accumulator wide enough for 12x16 products plus the sum
`define FFT_ACC_W      30

// schedule counter
`define FFT_CNT_W      8
`define FFT_START_CNT  96   // first count of stage 2
`define FFT_STAGE_LEN  32   // counts per stage

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the twiddle multiplier testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=twiddle_mult_sim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module twiddle_mult_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG_FILE"
    exit 1
fi

//--- tb.f
+incdir+include
design/fft_twiddle_pkg.sv
design/twiddle_addr_gen.sv
design/twiddle_rom.sv
design/complex_mult.sv
design/twiddle_mult.sv
verification/twiddle_mult_tb.sv

//--- verification/twiddle_mult_tb.sv
`timescale 1ns/1ps
`include "fft_params.svh"

module twiddle_mult_tb;

    localparam int RESET_TIMEOUT = 20;  // cycles
    localparam int RANDOM_ROWS   = 100;

    logic                        clk;
    logic                        rst_n;
    logic [`FFT_CNT_W-1:0]       cnt;
    fft_twiddle_pkg::cplx_word_u data_in;
    fft_twiddle_pkg::cplx_word_u data_out;

    // real and imaginary parts of W64^k in Q1.10 from the reference table
    int coef_re[`FFT_TW_NUM] = '{
        1024, 1019, 1004,  979,  946,  903,  851,  791,
         724,  649,  568,  482,  391,  297,  199,  100,
           0, -101, -200, -298, -392, -483, -569, -650,
        -725, -792, -852, -904, -947, -980, -1005, -1020
    };
    int coef_im[`FFT_TW_NUM] = '{
           0, -101, -200, -298, -392, -483, -569, -650,
        -725, -792, -852, -904, -947, -980, -1005, -1020,
        -1024, -1020, -1005, -980, -947, -904, -852, -792,
        -725, -650, -569, -483, -392, -298, -200, -101
    };

    // stimulus table of cnt, sample and expected product
    logic [`FFT_CNT_W-1:0]    stim_cnt[$];
    logic [`FFT_SAMPLE_W-1:0] stim_data[$];
    logic [`FFT_SAMPLE_W-1:0] stim_exp[$];

    twiddle_mult UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cnt      (cnt),
        .data_in  (data_in),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            fail_run("data_out differs from the reference model");
        end
    endtask

    // stage 1 uses W(0) and later stages repeat with period 2^(g+1)
    function automatic int index_of(input int c);
        int off;
        int g;
        int p;
        if (c < `FFT_START_CNT)
            return 0;
        off = c - `FFT_START_CNT;
        g   = off / `FFT_STAGE_LEN;
        p   = off % `FFT_STAGE_LEN;
        return (p % (1 << (g + 1))) * ((`FFT_TW_NUM / 2) >> g);
    endfunction

    function automatic int cnt_for_index(input int idx);
        for (int c = 0; c < (1 << `FFT_CNT_W); c++) begin
            if (index_of(c) == idx)
                return c;
        end
        return -1;
    endfunction

    // division by 2^FFT_TW_FRAC rounded toward minus infinity
    function automatic longint floor_scale(input longint num);
        longint den;
        longint q;
        den = longint'(1) << `FFT_TW_FRAC;
        q   = num / den;
        if ((num % den != 0) && (num < 0))
            q = q - 1;
        return q;
    endfunction

    function automatic logic [`FFT_PART_W-1:0] wrap_part(input longint v);
        return v[`FFT_PART_W-1:0];
    endfunction

    function automatic logic [`FFT_SAMPLE_W-1:0] model_out(input int idx,
                                                           input logic [31:0] word);
        longint re;
        longint im;
        longint wr;
        longint wi;
        longint sum_re;
        longint sum_im;
        re     = longint'($signed(word[31:16]));
        im     = longint'($signed(word[15:0]));
        wr     = longint'(coef_re[idx]);
        wi     = longint'(coef_im[idx]);
        sum_re = wr * re - wi * im;
        sum_im = wi * re + wr * im;
        return {wrap_part(floor_scale(sum_re)), wrap_part(floor_scale(sum_im))};
    endfunction

    task automatic add_row(input int c, input logic [31:0] d);
        stim_cnt.push_back(`FFT_CNT_W'(c));
        stim_data.push_back(d);
        stim_exp.push_back(model_out(index_of(c), d));
    endtask

    task automatic build_table();
        int corner[4]     = '{-32768, 32767, 0, -1};
        int corner_idx[4] = '{0, 8, 16, 24};
        int c;
        fft_twiddle_pkg::cplx_word_u w;
        for (c = 0; c < `FFT_START_CNT; c++) begin  // stage 1 is the identity
            add_row(c, $urandom);
        end
        for (c = `FFT_START_CNT; c < (1 << `FFT_CNT_W); c++) begin
            add_row(c, $urandom);
        end
        for (int k = 0; k < 4; k++) begin
            c = cnt_for_index(corner_idx[k]);
            if (c < 0)
                fail_run("no count maps onto a corner twiddle index");
            for (int r = 0; r < 4; r++) begin
                for (int q = 0; q < 4; q++) begin
                    w.parts.re = 16'(corner[r]);
                    w.parts.im = 16'(corner[q]);
                    add_row(c, w.raw);
                end
            end
        end
        // random order exercises the 1-cycle twiddle latency
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            add_row(int'($urandom % (1 << `FFT_CNT_W)), $urandom);
        end
    endtask

    initial begin
        int                       wait_cnt;
        int                       rows;
        logic [`FFT_SAMPLE_W-1:0] rnd;
        logic [`FFT_SAMPLE_W-1:0] exp_word;

        void'($urandom(32'hbae4dfb4));
        cnt         = '0;
        data_in.raw = '0;
        build_table();
        rows = stim_cnt.size();

        // twiddle is W(0) during reset and right after release
        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            if (wait_cnt > RESET_TIMEOUT)
                fail_run("timeout waiting for reset release");
            @(negedge clk);
            rnd         = $urandom;
            data_in.raw = rnd;
            #1;
            check_value("data_out in reset", data_out.raw, rnd);
            wait_cnt++;
        end

        for (int i = 0; i <= rows; i++) begin
            @(negedge clk);
            if (i < rows)
                cnt = stim_cnt[i];
            if (i == 0) begin
                rnd         = $urandom;  // twiddle still from cnt 0
                data_in.raw = rnd;
                exp_word    = rnd;
            end else begin
                data_in.raw = stim_data[i-1];
                exp_word    = stim_exp[i-1];
            end
            #1;
            check_value($sformatf("data_out row %0d", i - 1), data_out.raw, exp_word);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
